/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := huff_tb
FILELIST  := list.f
SIM       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* bench/huff_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module huff_tb
  import huff_pkg::*;
;

  // seven blocks of at most about 2100 cycles each (build, codes and 64 symbols of encode)
  localparam int TIMEOUT_CYCLES = 20000;

  logic       hwclk, arst_n, start, sym_valid, sym_last;
  logic [3:0] sym;
  logic [2:0] phase;
  logic       sym_ready, bit_out, bit_valid, done, error;

  int          cycles = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] seed = 32'hd214;

  // current block and the expected results for it
  logic [3:0]  blk [$];
  int          exp_len [16];
  logic [14:0] exp_code [16];
  bit          exp_bits [$];

  huff_top #(.SYM_BITS(4), .CNT_BITS(8)) huff_top_i (
    .hwclk(hwclk), .arst_n(arst_n), .start(start), .sym(sym),
    .sym_valid(sym_valid), .sym_last(sym_last), .phase(phase),
    .sym_ready(sym_ready), .bit_out(bit_out), .bit_valid(bit_valid),
    .done(done), .error(error)
  );

  always #50 hwclk = ~hwclk;

  always @(posedge hwclk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the DUT never signalled done", cycles);
      $display("Errors found");
      $finish;
    end
  end

  task automatic step();
    @(posedge hwclk);
    #1;
  endtask

  task automatic check_value(input string name, input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("[FAIL] %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  // huffman tree, depths and canonical codes worked out from the counts
  task automatic build_model();
    int w [31];
    int par [31];
    bit lv [31];
    int nxt, nlive, a, b, d, n, run;
    for (int i = 0; i < 31; i++) begin
      w[i] = 0;
      par[i] = -1;
      lv[i] = 0;
    end
    foreach (blk[k]) w[blk[k]]++;
    nlive = 0;
    for (int i = 0; i < 16; i++) begin
      lv[i] = (w[i] != 0);
      nlive += lv[i];
    end
    nxt = 16;
    while (nlive > 1) begin
      a = -1;
      b = -1;
      // lightest first and the lower index wins a tie
      for (int i = 0; i < nxt; i++) begin
        if (lv[i] && (a < 0 || w[i] < w[a])) begin
          b = a;
          a = i;
        end else if (lv[i] && (b < 0 || w[i] < w[b])) begin
          b = i;
        end
      end
      w[nxt] = w[a] + w[b];
      par[a] = nxt;
      par[b] = nxt;
      lv[a] = 0;
      lv[b] = 0;
      lv[nxt] = 1;
      nxt++;
      nlive--;
    end
    for (int i = 0; i < 16; i++) begin
      d = 0;
      n = i;
      while (par[n] >= 0) begin
        d++;
        n = par[n];
      end
      exp_len[i] = (w[i] == 0) ? 0 : ((d == 0) ? 1 : d);
    end
    run = 0;
    for (int len = 1; len < 16; len++) begin
      for (int s = 0; s < 16; s++) begin
        if (exp_len[s] == len) begin
          exp_code[s] = 15'(run);
          run++;
        end
      end
      run = run << 1;
    end
    exp_bits.delete();
    foreach (blk[k]) begin
      for (int j = exp_len[blk[k]] - 1; j >= 0; j--) exp_bits.push_back(exp_code[blk[k]][j]);
    end
  endtask

  // count pass, then encode pass with the first symbol held from the build phase on
  task automatic run_block(input string name, input int gap_mod);
    bit got [$];
    int k, n, gap_left, due;
    bit took_prev, seen_done, bad, rise_due;
    n = blk.size();
    build_model();
    start = 1'b1;
    step();
    start = 1'b0;
    check_value({name, " phase after start"}, PH_COUNT, phase);
    check_value({name, " error after start"}, 0, error);
    if (n == 0) begin
      sym_valid = 1'b0;
      sym_last = 1'b1;
      step();
    end
    for (int i = 0; i < n; i++) begin
      sym = blk[i];
      sym_valid = 1'b1;
      sym_last = (i == n - 1);
      step();
    end
    k = 0;
    due = 0;
    rise_due = 0;
    gap_left = 0;
    took_prev = 0;
    seen_done = 0;
    while (!seen_done) begin
      if (bit_valid) got.push_back(bit_out);
      if (rise_due && !sym_ready) begin
        errors++;
        $display("%s: sym_ready did not rise after the last bit of symbol %0d", name, k - 1);
      end
      rise_due = 0;
      if (took_prev) begin
        if (!bit_valid) begin
          errors++;
          $display("%s: symbol %0d was taken but no bit came in the next cycle", name, k);
        end
        // bits of this code follow on consecutive cycles
        due = exp_len[blk[k]];
        k++;
        gap_left = (gap_mod > 0) ? k % gap_mod : 0;
      end
      if (due > 0) begin
        if (sym_ready) begin
          errors++;
          $display("%s: sym_ready is high while symbol %0d is still being sent", name, k - 1);
        end
        due--;
        rise_due = (due == 0) && (k < n);
      end
      if (done) begin
        seen_done = 1;
      end else begin
        if (k < n && gap_left == 0) begin
          sym = blk[k];
          sym_valid = 1'b1;
          sym_last = (k == n - 1);
        end else begin
          sym_valid = 1'b0;
          sym_last = 1'b0;
          if (gap_left > 0) gap_left--;
        end
        took_prev = sym_valid && sym_ready;
        step();
      end
    end
    check_value({name, " error at done"}, (n == 0), error);
    if (got.size() != exp_bits.size()) begin
      errors++;
      $display("%s: DUT sent %0d bits, the code lengths add up to %0d", name, got.size(),
               exp_bits.size());
    end else begin
      bad = 0;
      foreach (got[i]) begin
        if (!bad && got[i] != exp_bits[i]) begin
          bad = 1;
          errors++;
          $display("[FAIL] %s bit %0d: expected %0b actual %0b", name, i, exp_bits[i], got[i]);
        end
      end
    end
    step();
    check_value({name, " phase after done"}, PH_IDLE, phase);
    check_value({name, " done one cycle later"}, 0, done);
  endtask

  task automatic print_result(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("%s: failed", name);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  task automatic reset_and_single();
    int e;
    e = errors;
    check_value("reset_and_single phase at reset", PH_IDLE, phase);
    check_value("reset_and_single sym_ready at reset", 0, sym_ready);
    check_value("reset_and_single bit_valid at reset", 0, bit_valid);
    check_value("reset_and_single done at reset", 0, done);
    check_value("reset_and_single error at reset", 0, error);
    blk = '{9};
    run_block("reset_and_single", 0);
    print_result("reset_and_single", e);
  endtask

  task automatic skewed_block();
    int e;
    e = errors;
    blk = '{3, 5, 3, 9, 3, 5, 12, 3, 3, 5, 14, 3, 9, 3, 5, 3};
    run_block("skewed_block", 0);
    print_result("skewed_block", e);
  endtask

  task automatic tie_block();
    int e;
    e = errors;
    blk = '{2, 7, 10, 13, 13, 10, 7, 2};
    run_block("tie_block", 0);
    print_result("tie_block", e);
  endtask

  task automatic random_block(input string name, input int len, input int gap_mod);
    int e;
    logic [31:0] r;
    e = errors;
    blk.delete();
    for (int i = 0; i < len; i++) begin
      r = $random(seed);
      blk.push_back(r[3:0]);
    end
    run_block(name, gap_mod);
    print_result(name, e);
  endtask

  task automatic empty_block();
    int e;
    e = errors;
    blk.delete();
    run_block("empty_block", 0);
    // next start has to clear the flag
    blk = '{6, 6, 1};
    run_block("empty_block restart", 0);
    print_result("empty_block", e);
  endtask

  initial begin
    hwclk = 1'b0;
    arst_n = 1'b0;
    start = 1'b0;
    sym = '0;
    sym_valid = 1'b0;
    sym_last = 1'b0;
    repeat (2) @(posedge hwclk);
    #1 arst_n = 1'b1;
    step();
    reset_and_single();
    skewed_block();
    tie_block();
    random_block("random_block", 64, 0);
    random_block("backpressure_block", 24, 3);
    empty_block();
    $display("tests run %0d, tests failed %0d, checks failed %0d", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
verilog/huff_pkg.sv
verilog/huff_node_if.sv
verilog/huff_controller.sv
verilog/huff_histogram.sv
verilog/huff_find_least.sv
verilog/huff_tree_build.sv
verilog/huff_codebook.sv
verilog/huff_translation.sv
verilog/huff_top.sv
bench/huff_tb.sv

/* verilog/huff_codebook.sv */
`timescale 1ns/1ps
`default_nettype none

module huff_codebook
  import huff_pkg::*;
#(
  parameter int SYM_BITS = 4
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [2:0]              phase,
  output logic [SYM_BITS-1:0]     len_idx,
  input  logic [SYM_BITS-1:0]     len_val,
  input  logic [SYM_BITS-1:0]     sym_lookup,
  output logic [2**SYM_BITS-2:0]  code,
  output logic [SYM_BITS-1:0]     code_len,
  output logic                    codes_fin
);

  localparam int NSYM      = 2**SYM_BITS;
  localparam int CODE_BITS = NSYM - 1;

  logic [SYM_BITS-1:0]  s_idx, cur_len;
  logic [CODE_BITS-1:0] running, running_inc;
  logic [CODE_BITS-1:0] code_tab [NSYM];
  logic                 passes_done, run, hit;

  assign run         = (phase == PH_CODES) && !passes_done;
  // length 0 never matches, cur_len starts at 1
  assign hit         = run && (len_val == cur_len);
  assign running_inc = running + CODE_BITS'(hit);

  // lengths stay in the tree builder, shared read port
  assign len_idx  = (phase == PH_ENCODE) ? sym_lookup : s_idx;
  assign code     = code_tab[sym_lookup];
  assign code_len = len_val;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s_idx       <= '0;
      cur_len     <= SYM_BITS'(1);
      running     <= '0;
      passes_done <= 1'b0;
      codes_fin   <= 1'b0;
    end else begin
      codes_fin <= 1'b0;
      if (phase != PH_CODES) begin
        s_idx       <= '0;
        cur_len     <= SYM_BITS'(1);
        running     <= '0;
        passes_done <= 1'b0;
      end else if (!passes_done) begin
        s_idx <= s_idx + 1'b1;
        if (s_idx == SYM_BITS'(NSYM - 1)) begin
          // next length, codes get one bit longer
          running <= running_inc << 1;
          cur_len <= cur_len + 1'b1;
          if (cur_len == '1) begin
            codes_fin   <= 1'b1;
            passes_done <= 1'b1;
          end
        end else begin
          running <= running_inc;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      code_tab[s_idx] <= running;
    end
  end

endmodule

`default_nettype wire

/* verilog/huff_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module huff_controller
  import huff_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       start,
  input  logic       count_fin,
  input  logic       build_fin,
  input  logic       codes_fin,
  input  logic       enc_fin,
  input  logic       empty,
  output logic [2:0] phase,
  output logic       done,
  output logic       error
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase <= PH_IDLE;
      error <= 1'b0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (start) begin
            phase <= PH_COUNT;
            error <= 1'b0;
          end
        end
        PH_COUNT: begin
          if (count_fin) begin
            phase <= PH_BUILD;
          end
        end
        PH_BUILD: begin
          // nothing counted, no tree to build
          if (empty) begin
            phase <= PH_DONE;
            error <= 1'b1;
          end else if (build_fin) begin
            phase <= PH_CODES;
          end
        end
        PH_CODES: begin
          if (codes_fin) begin
            phase <= PH_ENCODE;
          end
        end
        PH_ENCODE: begin
          if (enc_fin) begin
            phase <= PH_DONE;
          end
        end
        default: begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

  assign done = (phase == PH_DONE);

  // each stage may only finish inside its own phase
  a_fin_in_phase: assert property (@(posedge clk) disable iff (!arst_n)
    (!count_fin || phase == PH_COUNT) && (!build_fin || phase == PH_BUILD) &&
    (!codes_fin || phase == PH_CODES) && (!enc_fin || phase == PH_ENCODE));

endmodule

`default_nettype wire

/* verilog/huff_find_least.sv */
`timescale 1ns/1ps
`default_nettype none

module huff_find_least #(
  parameter int SYM_BITS = 4,
  parameter int CNT_BITS = 8
) (
  input  logic        clk,
  input  logic        arst_n,
  huff_node_if.finder nif
);

  localparam int NODE_BITS = SYM_BITS + 1;
  localparam int NODES     = 2**NODE_BITS - 1;

  logic                 busy;
  logic [NODE_BITS-1:0] idx;
  logic [NODE_BITS-1:0] b1_idx, b2_idx;
  logic [CNT_BITS:0]    b1_w, b2_w;
  logic                 b1_v, b2_v;
  logic                 take1, take2;

  assign nif.rd_idx = idx;
  assign nif.least1 = b1_idx;
  assign nif.least2 = b2_idx;

  // strict compare, so on a tie the lower index stays
  assign take1 = busy && nif.rd_live && (!b1_v || nif.rd_weight < b1_w);
  assign take2 = busy && nif.rd_live && !take1 && (!b2_v || nif.rd_weight < b2_w);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy          <= 1'b0;
      idx           <= '0;
      b1_idx        <= '0;
      b2_idx        <= '0;
      b1_w          <= '0;
      b2_w          <= '0;
      b1_v          <= 1'b0;
      b2_v          <= 1'b0;
      nif.scan_done <= 1'b0;
    end else begin
      nif.scan_done <= 1'b0;
      if (nif.scan_start) begin
        busy <= 1'b1;
        idx  <= '0;
        b1_v <= 1'b0;
        b2_v <= 1'b0;
      end else if (busy) begin
        if (take1) begin
          // old best drops to second place
          b2_idx <= b1_idx;
          b2_w   <= b1_w;
          b2_v   <= b1_v;
          b1_idx <= idx;
          b1_w   <= nif.rd_weight;
          b1_v   <= 1'b1;
        end else if (take2) begin
          b2_idx <= idx;
          b2_w   <= nif.rd_weight;
          b2_v   <= 1'b1;
        end
        idx <= idx + 1'b1;
        if (idx == NODE_BITS'(NODES - 1)) begin
          busy          <= 1'b0;
          nif.scan_done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/huff_histogram.sv */
`timescale 1ns/1ps
`default_nettype none

module huff_histogram
  import huff_pkg::*;
#(
  parameter int SYM_BITS = 4,
  parameter int CNT_BITS = 8
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [2:0]          phase,
  input  logic [SYM_BITS-1:0] sym,
  input  logic                sym_valid,
  input  logic                sym_last,
  input  logic [SYM_BITS-1:0] cnt_idx,
  output logic [CNT_BITS-1:0] cnt_val,
  output logic                count_fin,
  output logic                empty
);

  localparam int NSYM = 2**SYM_BITS;

  logic [CNT_BITS-1:0] cnt [NSYM];
  logic [CNT_BITS-1:0] total;
  logic                hit;

  assign hit = (phase == PH_COUNT) && sym_valid;

  // counters start from zero for every block
  always_ff @(posedge clk) begin
    if (phase == PH_IDLE) begin
      for (int i = 0; i < NSYM; i++) begin
        cnt[i] <= '0;
      end
    end else if (hit) begin
      cnt[sym] <= cnt[sym] + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      total <= '0;
    end else if (phase == PH_IDLE) begin
      total <= '0;
    end else if (hit) begin
      total <= total + 1'b1;
    end
  end

  // sym_last ends the block even without a valid symbol
  assign count_fin = (phase == PH_COUNT) && sym_last;
  assign empty     = (total == '0);
  assign cnt_val   = cnt[cnt_idx];

  a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
    hit |-> (cnt[sym] != '1) && (total != '1));

endmodule

`default_nettype wire

/* verilog/huff_node_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface huff_node_if #(
  parameter int SYM_BITS = 4,
  parameter int CNT_BITS = 8
);

  // scan control
  logic                scan_start;
  logic                scan_done;

  // node table read port, answered combinationally by the builder
  logic [SYM_BITS:0]   rd_idx;
  logic [CNT_BITS:0]   rd_weight;
  logic                rd_live;

  // two lightest live nodes of the last scan
  logic [SYM_BITS:0]   least1;
  logic [SYM_BITS:0]   least2;

  modport finder (
    input  scan_start, rd_weight, rd_live,
    output scan_done, rd_idx, least1, least2
  );

  modport builder (
    output scan_start, rd_weight, rd_live,
    input  scan_done, rd_idx, least1, least2
  );

endinterface

`default_nettype wire

/* verilog/huff_pkg.sv */
`default_nettype none

package huff_pkg;

  // controller phases, one stage active per phase
  localparam logic [2:0] PH_IDLE   = 3'd0;
  localparam logic [2:0] PH_COUNT  = 3'd1;
  localparam logic [2:0] PH_BUILD  = 3'd2;
  localparam logic [2:0] PH_CODES  = 3'd3;
  localparam logic [2:0] PH_ENCODE = 3'd4;

  // one cycle only, done pulses here
  localparam logic [2:0] PH_DONE   = 3'd5;

  // parent entry of the root node
  // never a real index, the top node is 30
  localparam logic [4:0] NO_PARENT = 5'h1f;

endpackage

`default_nettype wire

/* verilog/huff_top.sv */
`timescale 1ns/1ps
`default_nettype none

module huff_top #(
  parameter int SYM_BITS = 4,
  parameter int CNT_BITS = 8
) (
  input  logic                hwclk,
  input  logic                arst_n,
  input  logic                start,
  input  logic [SYM_BITS-1:0] sym,
  input  logic                sym_valid,
  input  logic                sym_last,
  output logic [2:0]          phase,
  output logic                sym_ready,
  output logic                bit_out,
  output logic                bit_valid,
  output logic                done,
  output logic                error
);

  localparam int CODE_BITS = 2**SYM_BITS - 1;

  // stage finish pulses
  logic count_fin, build_fin, codes_fin, enc_fin;
  logic empty;

  // histogram to tree builder
  logic [SYM_BITS-1:0]  cnt_idx;
  logic [CNT_BITS-1:0]  cnt_val;

  // lengths, codes and lookup
  logic [SYM_BITS-1:0]  len_idx, len_val;
  logic [SYM_BITS-1:0]  sym_lookup, code_len;
  logic [CODE_BITS-1:0] code;

  huff_node_if #(.SYM_BITS(SYM_BITS), .CNT_BITS(CNT_BITS)) node_if ();

  huff_controller controller (
    .clk(hwclk), .arst_n(arst_n), .start(start),
    .count_fin(count_fin), .build_fin(build_fin), .codes_fin(codes_fin),
    .enc_fin(enc_fin), .empty(empty),
    .phase(phase), .done(done), .error(error)
  );

  huff_histogram #(.SYM_BITS(SYM_BITS), .CNT_BITS(CNT_BITS)) histogram (
    .clk(hwclk), .arst_n(arst_n), .phase(phase),
    .sym(sym), .sym_valid(sym_valid), .sym_last(sym_last),
    .cnt_idx(cnt_idx), .cnt_val(cnt_val),
    .count_fin(count_fin), .empty(empty)
  );

  huff_find_least #(.SYM_BITS(SYM_BITS), .CNT_BITS(CNT_BITS)) find_least (
    .clk(hwclk), .arst_n(arst_n), .nif(node_if.finder)
  );

  huff_tree_build #(.SYM_BITS(SYM_BITS), .CNT_BITS(CNT_BITS)) tree_build (
    .clk(hwclk), .arst_n(arst_n), .phase(phase),
    .cnt_idx(cnt_idx), .cnt_val(cnt_val), .nif(node_if.builder),
    .len_idx(len_idx), .len_val(len_val), .build_fin(build_fin)
  );

  huff_codebook #(.SYM_BITS(SYM_BITS)) codebook (
    .clk(hwclk), .arst_n(arst_n), .phase(phase),
    .len_idx(len_idx), .len_val(len_val),
    .sym_lookup(sym_lookup), .code(code), .code_len(code_len),
    .codes_fin(codes_fin)
  );

  huff_translation #(.SYM_BITS(SYM_BITS)) translation (
    .clk(hwclk), .arst_n(arst_n), .phase(phase),
    .sym(sym), .sym_valid(sym_valid), .sym_last(sym_last),
    .sym_ready(sym_ready), .sym_lookup(sym_lookup),
    .code(code), .code_len(code_len),
    .bit_out(bit_out), .bit_valid(bit_valid), .enc_fin(enc_fin)
  );

endmodule

`default_nettype wire

/* verilog/huff_translation.sv */
`timescale 1ns/1ps
`default_nettype none

module huff_translation
  import huff_pkg::*;
#(
  parameter int SYM_BITS = 4
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic [2:0]             phase,
  input  logic [SYM_BITS-1:0]    sym,
  input  logic                   sym_valid,
  input  logic                   sym_last,
  output logic                   sym_ready,
  output logic [SYM_BITS-1:0]    sym_lookup,
  input  logic [2**SYM_BITS-2:0] code,
  input  logic [SYM_BITS-1:0]    code_len,
  output logic                   bit_out,
  output logic                   bit_valid,
  output logic                   enc_fin
);

  localparam int CODE_BITS = 2**SYM_BITS - 1;

  logic [CODE_BITS-1:0] shreg;
  logic [SYM_BITS-1:0]  bits_left;
  logic                 last_q;
  logic                 take;

  assign sym_lookup = sym;
  assign sym_ready  = (phase == PH_ENCODE) && (bits_left == '0);
  assign take       = sym_valid && sym_ready;
  assign bit_out    = shreg[CODE_BITS-1];
  assign bit_valid  = (bits_left != '0);
  // high while the final bit of the block is out
  assign enc_fin    = last_q && (bits_left == SYM_BITS'(1));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      bits_left <= '0;
      last_q    <= 1'b0;
    end else if (take) begin
      bits_left <= code_len;
      last_q    <= sym_last;
    end else if (bits_left != '0) begin
      bits_left <= bits_left - 1'b1;
    end
  end

  // msb aligned so the first code bit sits on top
  always_ff @(posedge clk) begin
    if (take) begin
      shreg <= code << (SYM_BITS'(CODE_BITS) - code_len);
    end else if (bit_valid) begin
      shreg <= shreg << 1;
    end
  end

  a_code_len: assert property (@(posedge clk) disable iff (!arst_n)
    take |-> (code_len != '0));

endmodule

`default_nettype wire

/* verilog/huff_tree_build.sv */
`timescale 1ns/1ps
`default_nettype none

module huff_tree_build
  import huff_pkg::*;
#(
  parameter int SYM_BITS = 4,
  parameter int CNT_BITS = 8
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [2:0]          phase,
  output logic [SYM_BITS-1:0] cnt_idx,
  input  logic [CNT_BITS-1:0] cnt_val,
  huff_node_if.builder        nif,
  input  logic [SYM_BITS-1:0] len_idx,
  output logic [SYM_BITS-1:0] len_val,
  output logic                build_fin
);

  localparam int NSYM      = 2**SYM_BITS;
  localparam int NODES     = 2 * NSYM - 1;
  localparam int NODE_BITS = SYM_BITS + 1;

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_LOAD  = 3'd1;
  localparam logic [2:0] ST_START = 3'd2;
  localparam logic [2:0] ST_WAIT  = 3'd3;
  localparam logic [2:0] ST_WALK  = 3'd4;
  localparam logic [2:0] ST_DONE  = 3'd5;

  logic [2:0]           state;
  logic [CNT_BITS:0]    weight [NODES];
  logic [NODE_BITS-1:0] parent [NODES];
  logic [SYM_BITS-1:0]  len    [NSYM];
  logic [NODES-1:0]     live;
  logic [SYM_BITS-1:0]  leaf;
  logic [NODE_BITS-1:0] leaf_node, next_node, cur;
  logic [SYM_BITS:0]    n_live, n_live_ld;
  logic [SYM_BITS-1:0]  depth;
  logic                 active, merge, leaf_end;

  assign active    = (phase == PH_BUILD);
  assign leaf_node = {1'b0, leaf};
  assign cnt_idx   = leaf;
  assign n_live_ld = n_live + (cnt_val != '0);
  assign merge     = active && (state == ST_WAIT) && nif.scan_done;
  // unused leaf, or the walk reached the root
  assign leaf_end  = (weight[leaf_node] == '0) || (parent[cur] == NO_PARENT);

  assign nif.scan_start = (state == ST_START);
  assign nif.rd_weight  = weight[nif.rd_idx];
  assign nif.rd_live    = live[nif.rd_idx];
  assign len_val        = len[len_idx];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ST_IDLE;
      live      <= '0;
      leaf      <= '0;
      next_node <= '0;
      n_live    <= '0;
      cur       <= '0;
      depth     <= '0;
      build_fin <= 1'b0;
    end else begin
      build_fin <= 1'b0;
      if (!active) begin
        state <= ST_IDLE;
      end else begin
        case (state)
          ST_IDLE: begin
            live      <= '0;
            leaf      <= '0;
            n_live    <= '0;
            next_node <= NODE_BITS'(NSYM);
            state     <= ST_LOAD;
          end
          ST_LOAD: begin
            live[leaf] <= (cnt_val != '0);
            n_live     <= n_live_ld;
            // wraps back to leaf 0, ready for the depth walk
            leaf       <= leaf + 1'b1;
            if (leaf == SYM_BITS'(NSYM - 1)) begin
              cur   <= '0;
              depth <= '0;
              state <= (n_live_ld > 1) ? ST_START : ST_WALK;
            end
          end
          ST_START: begin
            state <= ST_WAIT;
          end
          ST_WAIT: begin
            if (merge) begin
              live[nif.least1] <= 1'b0;
              live[nif.least2] <= 1'b0;
              live[next_node]  <= 1'b1;
              next_node        <= next_node + 1'b1;
              n_live           <= n_live - 1'b1;
              state            <= (n_live == 2) ? ST_WALK : ST_START;
            end
          end
          ST_WALK: begin
            if (leaf_end) begin
              cur   <= leaf_node + 1'b1;
              depth <= '0;
              leaf  <= leaf + 1'b1;
              if (leaf == SYM_BITS'(NSYM - 1)) begin
                build_fin <= 1'b1;
                state     <= ST_DONE;
              end
            end else begin
              cur   <= parent[cur];
              depth <= depth + 1'b1;
            end
          end
          default: begin
            // hold until the controller moves on
            state <= ST_DONE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (active && state == ST_LOAD) begin
      weight[leaf_node] <= {1'b0, cnt_val};
      parent[leaf_node] <= NO_PARENT;
    end
    if (merge) begin
      weight[next_node]  <= weight[nif.least1] + weight[nif.least2];
      parent[next_node]  <= NO_PARENT;
      parent[nif.least1] <= next_node;
      parent[nif.least2] <= next_node;
    end
    if (active && state == ST_WALK && leaf_end) begin
      // a lone leaf still needs one bit
      if (weight[leaf_node] == '0) begin
        len[leaf] <= '0;
      end else begin
        len[leaf] <= (depth == '0) ? SYM_BITS'(1) : depth;
      end
    end
  end

  a_node_limit: assert property (@(posedge clk) disable iff (!arst_n)
    merge |-> (next_node < NODE_BITS'(NODES)));

endmodule

`default_nettype wire
